//--- Bender.yml
package:
  name: cpu16

export_include_dirs:
  - src

sources:
  - src/cpu16_pkg.sv
  - src/cpu16_alu.sv
  - src/cpu16_fetch.sv
  - src/cpu16_decode.sv
  - src/cpu16_execute.sv
  - src/cpu16_writeback.sv
  - src/cpu16_top.sv
  - target: test
    files:
      - verification/cpu16_tb.sv

//--- cpu16.f
+incdir+src
src/cpu16_pkg.sv
src/cpu16_alu.sv
src/cpu16_fetch.sv
src/cpu16_decode.sv
src/cpu16_execute.sv
src/cpu16_writeback.sv
src/cpu16_top.sv
verification/cpu16_tb.sv

//--- src/cpu16_alu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu16_alu
    import cpu16_pkg::*;
(
    input  wire opcode_t i_op,
    input  wire word_t   i_a,
    input  wire word_t   i_b,
    input  wire          i_carry,
    output word_t        o_result,
    output logic         o_carry
);

    always_comb
    begin
        o_result = '0;
        o_carry  = 1'b0;
        case (i_op)
            // Address sums
            LOAD, STORE, JMPR, BZ, BNZ, BN, BNN, BC, BNC:
                o_result = i_a + i_b;
            LDIH:
                o_result = i_a + {i_b[7:0], 8'h00};

            // Carry out is bit 16 of the sum, borrow for subtracts
            ADD, ADDI:
                {o_carry, o_result} = i_a + i_b;
            ADDC:
                {o_carry, o_result} = i_a + i_b + i_carry;
            SUB, SUBI, CMP:
                {o_carry, o_result} = i_a - i_b;
            SUBC:
                {o_carry, o_result} = i_a - i_b - i_carry;

            AND:
                o_result = i_a & i_b;
            OR:
                o_result = i_a | i_b;
            XOR:
                o_result = i_a ^ i_b;
            NAND:
                o_result = ~(i_a & i_b);
            NOR:
                o_result = ~(i_a | i_b);
            NXOR:
                o_result = ~(i_a ^ i_b);

            SLL:
                o_result = i_a << i_b;
            SRL:
                o_result = i_a >> i_b;
            SLA:
                o_result = $signed(i_a) <<< i_b;
            SRA:
                o_result = $signed(i_a) >>> i_b;

            JUMP:
                o_result = i_b;
            default:
                o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- src/cpu16_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu16_defs.svh"

module cpu16_decode
    import cpu16_pkg::*;
(
    input  wire                       i_clock,
    input  wire                       i_reset_n,
    input  wire                       i_exec,
    input  wire                       i_branch,
    input  wire word_t                i_id_ir,
    input  wire word_t                i_ex_result,
    input  wire word_t                i_mem_ir,
    input  wire word_t                i_mem_result,
    input  wire word_t                i_d_data,
    input  wire word_t                i_wb_ir,
    input  wire word_t                i_wb_value,
    input  wire word_t [`CPU16_NREGS-1:0] i_regs,
    output word_t                     o_ex_ir,
    output word_t                     o_reg_a,
    output word_t                     o_reg_b,
    output word_t                     o_store_data
);

    opcode_t  id_op;
    reg_idx_t id_r1;
    reg_idx_t id_r2;
    reg_idx_t id_r3;
    word_t    a_next;
    word_t    b_next;
    word_t    sd_next;

    // Youngest producer of a register wins
    function automatic word_t fwd(reg_idx_t src);
        word_t value;
        if (writes_reg(ir_op(o_ex_ir)) && ir_reg(o_ex_ir, `CPU16_R1_LSB) == src)
            value = i_ex_result;
        else if (writes_reg(ir_op(i_mem_ir)) && ir_reg(i_mem_ir, `CPU16_R1_LSB) == src)
            value = (ir_op(i_mem_ir) == LOAD) ? i_d_data : i_mem_result;
        else if (writes_reg(ir_op(i_wb_ir)) && ir_reg(i_wb_ir, `CPU16_R1_LSB) == src)
            value = i_wb_value;
        else
            value = i_regs[src];
        return value;
    endfunction

    assign id_op = ir_op(i_id_ir);
    assign id_r1 = ir_reg(i_id_ir, `CPU16_R1_LSB);
    assign id_r2 = ir_reg(i_id_ir, `CPU16_R2_LSB);
    assign id_r3 = ir_reg(i_id_ir, `CPU16_R3_LSB);

    //////////////////////////////////////////////////
    // Operand selection
    //////////////////////////////////////////////////

    always_comb
    begin
        a_next  = fwd(r1_based(id_op) ? id_r1 : id_r2);
        sd_next = '0;

        // Short immediate below the r2 field
        if (id_op inside {LOAD, STORE, SLL, SRL, SLA, SRA})
            b_next = word_t'(i_id_ir[`CPU16_R2_LSB-1:0]);
        // Byte immediate below the r1 field
        else if (r1_based(id_op) || id_op == JUMP)
            b_next = word_t'(i_id_ir[`CPU16_R1_LSB-1:0]);
        else
            b_next = fwd(id_r3);

        if (id_op == STORE)
            sd_next = fwd(id_r1);
    end

    //////////////////////////////////////////////////
    // Execute stage registers
    //////////////////////////////////////////////////

    always_ff @(posedge i_clock or negedge i_reset_n)
    begin
        if (!i_reset_n)
            o_ex_ir <= '0;
        else if (i_exec)
            o_ex_ir <= i_branch ? '0 : i_id_ir;
    end

    always_ff @(posedge i_clock)
    begin
        if (i_exec)
        begin
            o_reg_a      <= a_next;
            o_reg_b      <= b_next;
            o_store_data <= sd_next;
        end
    end

    // Unused codes sit between SUBC and NOR
    a_known_op: assert property (@(posedge i_clock) disable iff (!i_reset_n)
        i_exec |=> !$isunknown(o_ex_ir)
            && !(o_ex_ir[`CPU16_OP_MSB:`CPU16_OP_LSB] inside {[SUBC + 1 : NOR - 1]}));

endmodule

`default_nettype wire

//--- src/cpu16_defs.svh
`ifndef CPU16_DEFS_SVH
`define CPU16_DEFS_SVH

// Word and address sizes
`define CPU16_DATA_W 16
`define CPU16_ADDR_W 8
`define CPU16_NREGS  8

// Instruction fields
`define CPU16_OP_MSB 15
`define CPU16_OP_LSB 11
`define CPU16_R1_LSB 8
`define CPU16_R2_LSB 4
`define CPU16_R3_LSB 0

`endif

//--- src/cpu16_execute.sv
`timescale 1ns/1ps
`default_nettype none

module cpu16_execute
    import cpu16_pkg::*;
(
    input  wire        i_clock,
    input  wire        i_reset_n,
    input  wire        i_exec,
    input  wire word_t i_ex_ir,
    input  wire word_t i_reg_a,
    input  wire word_t i_reg_b,
    input  wire word_t i_store_data,
    output word_t      o_ex_result,
    output word_t      o_mem_ir,
    output word_t      o_mem_result,
    output word_t      o_d_wdata,
    output logic       o_d_we,
    output logic       o_zero,
    output logic       o_negative,
    output logic       o_branch
);

    opcode_t ex_op;
    opcode_t mem_op;
    logic    carry;
    logic    alu_carry;

    assign ex_op  = ir_op(i_ex_ir);
    assign mem_op = ir_op(o_mem_ir);

    cpu16_alu u_alu (
        .i_op     (ex_op),
        .i_a      (i_reg_a),
        .i_b      (i_reg_b),
        .i_carry  (carry),
        .o_result (o_ex_result),
        .o_carry  (alu_carry)
    );

    // Branch resolved in the memory stage
    always_comb
    begin
        case (mem_op)
            BZ:         o_branch = o_zero;
            BNZ:        o_branch = !o_zero;
            BN:         o_branch = o_negative;
            BNN:        o_branch = !o_negative;
            BC:         o_branch = carry;
            BNC:        o_branch = !carry;
            JUMP, JMPR: o_branch = 1'b1;
            default:    o_branch = 1'b0;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            o_mem_ir   <= '0;
            o_d_we     <= 1'b0;
            o_zero     <= 1'b0;
            o_negative <= 1'b0;
            carry      <= 1'b0;
        end
        else if (i_exec)
        begin
            o_mem_ir <= o_branch ? '0 : i_ex_ir;
            o_d_we   <= (ex_op == STORE) && !o_branch;
            // Squashed instruction leaves the flags alone
            if (!o_branch)
            begin
                if (ex_op inside {LDIH, ADD, ADDI, ADDC, SUB, SUBI, SUBC, CMP})
                begin
                    o_zero     <= (o_ex_result == '0);
                    o_negative <= o_ex_result[$bits(word_t)-1];
                end
                if (ex_op inside {ADD, ADDI, ADDC, SUB, SUBI, SUBC, CMP})
                    carry <= alu_carry;
            end
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_exec)
        begin
            o_mem_result <= o_ex_result;
            o_d_wdata    <= i_store_data;
        end
    end

endmodule

`default_nettype wire

//--- src/cpu16_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu16_defs.svh"

module cpu16_fetch
    import cpu16_pkg::*;
(
    input  wire        i_clock,
    input  wire        i_reset_n,
    input  wire        i_enable,
    input  wire        i_start,
    input  wire word_t i_i_data,
    input  wire        i_branch,
    input  wire addr_t i_branch_target,
    input  wire        i_halt,
    output logic       o_exec,
    output logic       o_running,
    output addr_t      o_pc,
    output word_t      o_id_ir
);

    run_state_t state;
    run_state_t state_next;
    opcode_t    in_op;
    reg_idx_t   ld_r1;
    logic       load_use;

    //////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////

    always_comb
    begin
        state_next = state;
        case (state)
            RUN_IDLE:
                if (i_enable && i_start)
                    state_next = RUN_EXEC;
            RUN_EXEC:
                if (!i_enable || i_halt)
                    state_next = RUN_IDLE;
        endcase
    end

    always_ff @(posedge i_clock or negedge i_reset_n)
    begin
        if (!i_reset_n)
            state <= RUN_IDLE;
        else
            state <= state_next;
    end

    assign o_exec    = (state == RUN_EXEC);
    assign o_running = (state == RUN_EXEC);

    //////////////////////////////////////////////////
    // Load-use hazard and instruction fetch
    //////////////////////////////////////////////////

    assign in_op = ir_op(i_i_data);
    assign ld_r1 = ir_reg(o_id_ir, `CPU16_R1_LSB);

    // r2 compared for every class, a spare stall is harmless
    assign load_use = (ir_op(o_id_ir) == LOAD)
        && ((((in_op == STORE) || r1_based(in_op)) && ir_reg(i_i_data, `CPU16_R1_LSB) == ld_r1)
            || (reg_reg(in_op) && ir_reg(i_i_data, `CPU16_R3_LSB) == ld_r1)
            || (ir_reg(i_i_data, `CPU16_R2_LSB) == ld_r1));

    always_ff @(posedge i_clock or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            o_pc    <= '0;
            o_id_ir <= '0;
        end
        else if (o_exec)
        begin
            if (i_branch)
            begin
                o_pc    <= i_branch_target;
                o_id_ir <= '0;
            end
            else if (load_use)
                o_id_ir <= '0;
            else
            begin
                o_pc    <= o_pc + 1'b1;
                o_id_ir <= i_i_data;
            end
        end
    end

    // Fetch stops once halt or enable low has taken the core to idle
    a_pc_idle: assert property (@(posedge i_clock) disable iff (!i_reset_n)
        $past(o_exec && (i_halt || !i_enable)) |=> $stable(o_pc));

endmodule

`default_nettype wire

//--- src/cpu16_pkg.sv
`default_nettype none

`include "cpu16_defs.svh"

package cpu16_pkg;

    typedef logic [`CPU16_DATA_W-1:0] word_t;
    typedef logic [`CPU16_ADDR_W-1:0] addr_t;
    typedef logic [$clog2(`CPU16_NREGS)-1:0] reg_idx_t;

    typedef enum logic [4:0] {
        // Data transfer and arithmetic
        NOP  = 5'b00000, HALT = 5'b00001, LOAD = 5'b00010, STORE = 5'b00011,
        LDIH = 5'b10000, ADD  = 5'b01000, ADDI = 5'b01001, ADDC  = 5'b10001,
        SUB  = 5'b01010, SUBI = 5'b01011, SUBC = 5'b10010, CMP   = 5'b01100,
        // Logical and shift
        AND  = 5'b01101, OR   = 5'b01110, XOR  = 5'b01111,
        SLL  = 5'b00100, SLA  = 5'b00101, SRL  = 5'b00110, SRA   = 5'b00111,
        // Control
        JUMP = 5'b11000, JMPR = 5'b11001, BZ   = 5'b11010, BNZ   = 5'b11011,
        BN   = 5'b11100, BNN  = 5'b11101, BC   = 5'b11110, BNC   = 5'b11111,
        // Inverted logical
        NOR  = 5'b10101, NXOR = 5'b10110, NAND = 5'b10111
    } opcode_t;

    typedef enum logic {
        RUN_IDLE = 1'b0,
        RUN_EXEC = 1'b1
    } run_state_t;

    function automatic opcode_t ir_op(word_t ir);
        return opcode_t'(ir[`CPU16_OP_MSB:`CPU16_OP_LSB]);
    endfunction

    function automatic reg_idx_t ir_reg(word_t ir, int unsigned lsb);
        return ir[lsb +: $bits(reg_idx_t)];
    endfunction

    // Classes that commit r1 to the register file
    function automatic logic writes_reg(opcode_t op);
        return !(op inside {NOP, HALT, STORE, CMP, JUMP, JMPR, BZ, BNZ, BN, BNN, BC, BNC});
    endfunction

    // r1 is the A operand, 8-bit immediate in B
    function automatic logic r1_based(opcode_t op);
        return op inside {LDIH, ADDI, SUBI, JMPR, BZ, BNZ, BN, BNN, BC, BNC};
    endfunction

    function automatic logic reg_reg(opcode_t op);
        return op inside {ADD, ADDC, SUB, SUBC, CMP, AND, OR, XOR, NOR, NXOR, NAND};
    endfunction

endpackage

`default_nettype wire

//--- src/cpu16_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu16_defs.svh"

module cpu16_top
    import cpu16_pkg::*;
(
    input  wire        i_clock,
    input  wire        i_reset_n,
    input  wire        i_enable,
    input  wire        i_start,
    input  wire [3:0]  i_select_y,
    input  wire word_t i_i_data,
    input  wire word_t i_d_data,
    output addr_t      o_i_addr,
    output addr_t      o_d_addr,
    output word_t      o_d_wdata,
    output logic       o_d_we,
    output word_t      o_y,
    output logic       o_running
);

    logic  exec;
    logic  branch;
    logic  halt;
    logic  zero;
    logic  negative;
    word_t id_ir;
    word_t ex_ir;
    word_t mem_ir;
    word_t wb_ir;
    word_t reg_a;
    word_t reg_b;
    word_t store_data;
    word_t ex_result;
    word_t mem_result;
    word_t wb_value;
    word_t [`CPU16_NREGS-1:0] regs;

    // Memory-stage result doubles as data address and branch target
    assign o_d_addr = mem_result[`CPU16_ADDR_W-1:0];

    cpu16_fetch u_fetch (
        .i_clock         (i_clock),
        .i_reset_n       (i_reset_n),
        .i_enable        (i_enable),
        .i_start         (i_start),
        .i_i_data        (i_i_data),
        .i_branch        (branch),
        .i_branch_target (mem_result[`CPU16_ADDR_W-1:0]),
        .i_halt          (halt),
        .o_exec          (exec),
        .o_running       (o_running),
        .o_pc            (o_i_addr),
        .o_id_ir         (id_ir)
    );

    cpu16_decode u_decode (
        .i_clock      (i_clock),
        .i_reset_n    (i_reset_n),
        .i_exec       (exec),
        .i_branch     (branch),
        .i_id_ir      (id_ir),
        .i_ex_result  (ex_result),
        .i_mem_ir     (mem_ir),
        .i_mem_result (mem_result),
        .i_d_data     (i_d_data),
        .i_wb_ir      (wb_ir),
        .i_wb_value   (wb_value),
        .i_regs       (regs),
        .o_ex_ir      (ex_ir),
        .o_reg_a      (reg_a),
        .o_reg_b      (reg_b),
        .o_store_data (store_data)
    );

    cpu16_execute u_execute (
        .i_clock      (i_clock),
        .i_reset_n    (i_reset_n),
        .i_exec       (exec),
        .i_ex_ir      (ex_ir),
        .i_reg_a      (reg_a),
        .i_reg_b      (reg_b),
        .i_store_data (store_data),
        .o_ex_result  (ex_result),
        .o_mem_ir     (mem_ir),
        .o_mem_result (mem_result),
        .o_d_wdata    (o_d_wdata),
        .o_d_we       (o_d_we),
        .o_zero       (zero),
        .o_negative   (negative),
        .o_branch     (branch)
    );

    cpu16_writeback u_writeback (
        .i_clock      (i_clock),
        .i_reset_n    (i_reset_n),
        .i_exec       (exec),
        .i_branch     (branch),
        .i_mem_ir     (mem_ir),
        .i_mem_result (mem_result),
        .i_d_data     (i_d_data),
        .i_select_y   (i_select_y),
        .i_reg_a      (reg_a),
        .i_reg_b      (reg_b),
        .i_store_data (store_data),
        .i_id_ir      (id_ir),
        .i_d_we       (o_d_we),
        .i_zero       (zero),
        .i_negative   (negative),
        .i_pc         (o_i_addr),
        .o_wb_ir      (wb_ir),
        .o_wb_value   (wb_value),
        .o_regs       (regs),
        .o_halt       (halt),
        .o_y          (o_y)
    );

endmodule

`default_nettype wire

//--- src/cpu16_writeback.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu16_defs.svh"

module cpu16_writeback
    import cpu16_pkg::*;
(
    input  wire                  i_clock,
    input  wire                  i_reset_n,
    input  wire                  i_exec,
    input  wire                  i_branch,
    input  wire word_t           i_mem_ir,
    input  wire word_t           i_mem_result,
    input  wire word_t           i_d_data,
    input  wire [3:0]            i_select_y,
    input  wire word_t           i_reg_a,
    input  wire word_t           i_reg_b,
    input  wire word_t           i_store_data,
    input  wire word_t           i_id_ir,
    input  wire                  i_d_we,
    input  wire                  i_zero,
    input  wire                  i_negative,
    input  wire addr_t           i_pc,
    output word_t                o_wb_ir,
    output word_t                o_wb_value,
    output word_t [`CPU16_NREGS-1:0] o_regs,
    output logic                 o_halt,
    output word_t                o_y
);

    word_t status;

    //////////////////////////////////////////////////
    // Writeback register and register file
    //////////////////////////////////////////////////

    always_ff @(posedge i_clock or negedge i_reset_n)
    begin
        if (!i_reset_n)
        begin
            o_wb_ir <= '0;
            o_regs  <= '0;
        end
        else if (i_exec)
        begin
            o_wb_ir <= i_branch ? '0 : i_mem_ir;
            if (writes_reg(ir_op(o_wb_ir)))
                o_regs[ir_reg(o_wb_ir, `CPU16_R1_LSB)] <= o_wb_value;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_exec)
            o_wb_value <= (ir_op(i_mem_ir) == LOAD) ? i_d_data : i_mem_result;
    end

    assign o_halt = (ir_op(o_wb_ir) == HALT);

    //////////////////////////////////////////////////
    // Debug read-out
    //////////////////////////////////////////////////

    assign status = {3'b000, i_d_we, 2'b00, i_zero, i_negative, i_pc};

    always_comb
    begin
        case (i_select_y)
            4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7:
                o_y = o_regs[i_select_y[2:0]];
            4'd8:    o_y = i_reg_a;
            4'd9:    o_y = i_reg_b;
            4'd11:   o_y = i_mem_result;
            4'd12:   o_y = o_wb_value;
            4'd13:   o_y = i_store_data;
            4'd14:   o_y = i_id_ir;
            default: o_y = status;
        endcase
    end

    // A HALT in writeback commits nothing
    a_rf_exec_only: assert property (@(posedge i_clock) disable iff (!i_reset_n)
        o_halt |=> $stable(o_regs));

endmodule

`default_nettype wire

//--- verification/cpu16_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu16_defs.svh"

module cpu16_tb
    import cpu16_pkg::*;
();

    localparam int MEM_DEPTH = 1 << `CPU16_ADDR_W;
    localparam int NUM_CASES = 24;
    localparam int BODY_LEN  = 40;
    localparam int HALT_WAIT = 1000;

    logic       clock;
    logic       reset_n;
    logic       enable;
    logic       start;
    logic [3:0] select_y;
    word_t      imem_q = '0;
    word_t      dmem_q = '0;
    addr_t      i_addr;
    addr_t      d_addr;
    word_t      d_wdata;
    logic       d_we;
    word_t      y;
    logic       running;

    word_t imem [MEM_DEPTH];
    word_t dmem [MEM_DEPTH];
    word_t dmem_init [MEM_DEPTH];

    // Reference model state
    word_t m_dmem [MEM_DEPTH];
    word_t m_regs [`CPU16_NREGS];
    logic  m_zero;
    logic  m_negative;
    logic  m_carry;
    addr_t m_pc;

    opcode_t rr_ops [10] = '{ADD, ADDC, SUB, SUBC, AND, OR, XOR, NOR, NXOR, NAND};
    opcode_t ri_ops [3]  = '{LDIH, ADDI, SUBI};
    opcode_t sh_ops [4]  = '{SLL, SLA, SRL, SRA};
    opcode_t br_ops [8]  = '{BZ, BNZ, BN, BNN, BC, BNC, JUMP, JMPR};

    logic [31:0] seed     = 32'h9138b9d6;
    int          checks   = 0;
    int          errors   = 0;
    int          timeouts = 0;

    cpu16_top i_dut (
        .i_clock    (clock),
        .i_reset_n  (reset_n),
        .i_enable   (enable),
        .i_start    (start),
        .i_select_y (select_y),
        .i_i_data   (imem_q),
        .i_d_data   (dmem_q),
        .o_i_addr   (i_addr),
        .o_d_addr   (d_addr),
        .o_d_wdata  (d_wdata),
        .o_d_we     (d_we),
        .o_y        (y),
        .o_running  (running)
    );

    initial
    begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Memories answer within the cycle, writes land before the next read
    always @(negedge clock)
    begin
        if (!reset_n)
            dmem = dmem_init;
        else if (d_we === 1'b1)
            dmem[d_addr] = d_wdata;
        imem_q = imem[i_addr];
        dmem_q = dmem[d_addr];
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic int unsigned rand_below(input int unsigned n);
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed[31:8] % n;
    endfunction

    function automatic word_t encode(input opcode_t op, input reg_idx_t r1,
                                     input logic [7:0] low);
        return {op, r1, low};
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_status(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("FAIL %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic wait_running(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (running !== level && n < limit)
        begin
            @(negedge clock);
            n++;
        end
        if (running !== level)
        begin
            timeouts++;
            $display("Timeout: %s did not happen within %0d cycles", what, limit);
        end
    endtask

    task automatic apply_reset();
        @(negedge clock);
        reset_n = 1'b0;
        repeat (16) @(negedge clock);
        reset_n = 1'b1;
    endtask

    task automatic start_core();
        @(negedge clock);
        enable = 1'b1;
        start  = 1'b1;
        wait_running(1'b1, 4, "start of execution");
        start = 1'b0;
    endtask

    task automatic read_y(input logic [3:0] sel, output word_t value);
        @(negedge clock);
        select_y = sel;
        @(negedge clock);
        value = y;
    endtask

    task automatic clear_imem();
        int k;
        for (k = 0; k < MEM_DEPTH; k++)
            imem[k] = '0;
    endtask

    task automatic fill_dmem();
        int    k;
        word_t salt;
        salt = word_t'(rand_below(1 << 16));
        for (k = 0; k < MEM_DEPTH; k++)
            dmem_init[k] = (word_t'(k) * 16'h9e37) ^ salt;
    endtask

    //////////////////////////////////////////////////
    // Program generator and model
    //////////////////////////////////////////////////

    task automatic build_program();
        int       p;
        int       r;
        int       kind;
        int       target;
        int       halt_at;
        reg_idx_t d;
        reg_idx_t s2;
        reg_idx_t s3;
        reg_idx_t base;
        clear_imem();
        p = 0;
        // r0 stays zero as the branch base
        for (r = 1; r < `CPU16_NREGS; r++)
        begin
            imem[p]     = encode(LDIH, reg_idx_t'(r), 8'(rand_below(256)));
            imem[p + 1] = encode(ADDI, reg_idx_t'(r), 8'(rand_below(256)));
            p = p + 2;
        end
        halt_at = p + BODY_LEN;
        while (p < halt_at)
        begin
            d    = reg_idx_t'(1 + rand_below(7));
            s2   = reg_idx_t'(rand_below(8));
            s3   = reg_idx_t'(rand_below(8));
            base = (rand_below(2) == 0) ? reg_idx_t'(0) : s2;
            kind = rand_below(16);
            if (kind < 6)
                imem[p] = encode(rr_ops[rand_below(10)], d, {1'b0, s2, 1'b0, s3});
            else if (kind == 6)
                imem[p] = encode(CMP, d, {1'b0, s2, 1'b0, s3});
            else if (kind == 7)
                imem[p] = encode(ri_ops[rand_below(3)], d, 8'(rand_below(256)));
            else if (kind == 8)
                imem[p] = encode(sh_ops[rand_below(4)], d, {1'b0, s2, 4'(rand_below(16))});
            else if (kind < 11)
                imem[p] = encode(LOAD, d, {1'b0, base, 4'(rand_below(16))});
            else if (kind < 13)
                imem[p] = encode(STORE, s3, {1'b0, base, 4'(rand_below(16))});
            else
            begin
                // Forward only, never past the HALT
                target = p + 1 + rand_below(4);
                if (target > halt_at)
                    target = halt_at;
                imem[p] = encode(br_ops[rand_below(8)], reg_idx_t'(0), 8'(target));
            end
            p++;
        end
        imem[halt_at] = encode(HALT, reg_idx_t'(0), 8'h00);
    endtask

    task automatic set_zn(input word_t v);
        m_zero     = (v == '0);
        m_negative = v[15];
    endtask

    task automatic run_model();
        addr_t       pc;
        word_t       ir;
        word_t       a;
        word_t       b;
        word_t       res;
        word_t       addr_sum;
        logic [16:0] wide;
        opcode_t     op;
        reg_idx_t    d;
        logic [3:0]  sh;
        logic        taken;
        logic        halted;
        int          steps;
        int          k;
        for (k = 0; k < `CPU16_NREGS; k++)
            m_regs[k] = '0;
        m_dmem     = dmem_init;
        m_zero     = 1'b0;
        m_negative = 1'b0;
        m_carry    = 1'b0;
        pc         = '0;
        halted     = 1'b0;
        steps      = 0;
        while (!halted && steps < MEM_DEPTH)
        begin
            ir       = imem[pc];
            op       = opcode_t'(ir[15:11]);
            d        = ir[10:8];
            a        = m_regs[ir[6:4]];
            b        = m_regs[ir[2:0]];
            sh       = ir[3:0];
            addr_sum = a + word_t'(sh);
            taken    = 1'b0;
            case (op)
                ADD, ADDC, SUB, SUBC, CMP, ADDI, SUBI:
                begin
                    // Immediate forms work on r1 and the byte
                    if (op inside {ADDI, SUBI})
                    begin
                        a = m_regs[d];
                        b = word_t'(ir[7:0]);
                    end
                    case (op)
                        ADD, ADDI: wide = {1'b0, a} + {1'b0, b};
                        ADDC:      wide = {1'b0, a} + {1'b0, b} + {16'b0, m_carry};
                        SUBC:      wide = {1'b0, a} - {1'b0, b} - {16'b0, m_carry};
                        default:   wide = {1'b0, a} - {1'b0, b};
                    endcase
                    set_zn(wide[15:0]);
                    m_carry = wide[16];
                    if (op != CMP)
                        m_regs[d] = wide[15:0];
                end
                LDIH:
                begin
                    res = m_regs[d] + {ir[7:0], 8'h00};
                    set_zn(res);
                    m_regs[d] = res;
                end
                AND:      m_regs[d] = a & b;
                OR:       m_regs[d] = a | b;
                XOR:      m_regs[d] = a ^ b;
                NAND:     m_regs[d] = ~(a & b);
                NOR:      m_regs[d] = ~(a | b);
                NXOR:     m_regs[d] = ~(a ^ b);
                SLL, SLA: m_regs[d] = a << sh;
                SRL:      m_regs[d] = a >> sh;
                SRA:      m_regs[d] = $signed(a) >>> sh;
                LOAD:     m_regs[d] = m_dmem[addr_sum[7:0]];
                STORE:    m_dmem[addr_sum[7:0]] = m_regs[d];
                HALT:     halted = 1'b1;
                BZ:       taken = m_zero;
                BNZ:      taken = !m_zero;
                BN:       taken = m_negative;
                BNN:      taken = !m_negative;
                BC:       taken = m_carry;
                BNC:      taken = !m_carry;
                JUMP, JMPR: taken = 1'b1;
                default:  ;
            endcase
            // Pipeline keeps fetching while HALT drains to writeback
            if (halted)
                m_pc = pc + 8'd5;
            else if (taken && op == JUMP)
                pc = ir[7:0];
            else if (taken)
                pc = m_regs[d][7:0] + ir[7:0];
            else
                pc = pc + 8'd1;
            steps++;
        end
        if (!halted)
        begin
            errors++;
            $display("Model did not reach HALT within %0d steps", MEM_DEPTH);
        end
    endtask

    task automatic check_case(input int c);
        word_t v;
        int    k;
        for (k = 1; k < `CPU16_NREGS; k++)
        begin
            read_y(4'(k), v);
            check_word($sformatf("case %0d r%0d", c, k), v, m_regs[k]);
        end
        read_y(4'd0, v);
        check_status($sformatf("case %0d d_we", c), v[12], 1'b0);
        check_status($sformatf("case %0d zero", c), v[9], m_zero);
        check_status($sformatf("case %0d negative", c), v[8], m_negative);
        check_word($sformatf("case %0d pc", c), word_t'(v[7:0]), word_t'(m_pc));
        for (k = 0; k < MEM_DEPTH; k++)
            check_word($sformatf("case %0d dmem[%02h]", c, k), dmem[k], m_dmem[k]);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial
    begin
        int c;
        reset_n  = 1'b0;
        enable   = 1'b0;
        start    = 1'b0;
        select_y = 4'd0;
        clear_imem();
        fill_dmem();
        apply_reset();

        @(negedge clock);
        check_status("o_running after reset", running, 1'b0);
        check_status("o_d_we after reset", d_we, 1'b0);
        check_word("status after reset", y, '0);

        // Endless NOP stream stopped by enable
        start_core();
        repeat (20) @(negedge clock);
        enable = 1'b0;
        wait_running(1'b0, 4, "return to idle after enable low");
        check_status("o_running with enable low", running, 1'b0);

        for (c = 0; c < NUM_CASES; c++)
        begin
            build_program();
            fill_dmem();
            run_model();
            apply_reset();
            start_core();
            wait_running(1'b0, HALT_WAIT, "halt of the program");
            check_case(c);
        end

        $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("test passed");
        else
            $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire
